// File: hdl/compy_map_pkg.sv
package compy_map_pkg;

   // bus widths
   typedef logic [15:0] bus_addr_t;   // cpu and video bus address
   typedef logic [7:0]  bus_data_t;   // one data byte

   // decoded target of an address
   typedef enum logic [2:0] {
      TGT_NONE,   // unmapped
      TGT_RAM,
      TGT_VRAM,
      TGT_ROM,
      TGT_REGS    // bus register window
   } target_e;

   // main ram, bottom of the map
   localparam bus_addr_t RAM_BASE  = 16'h0000;
   localparam int        RAM_SIZE  = 4096;

   // video ram
   localparam bus_addr_t VRAM_BASE = 16'hA000;
   localparam int        VRAM_SIZE = 2048;

   // font rom, top of the map
   localparam bus_addr_t ROM_BASE  = 16'hE000;
   localparam int        ROM_SIZE  = 64;

   // register window next to the io devices
   localparam bus_addr_t REG_BASE  = 16'h9000;
   localparam int        REG_SIZE  = 128;

   // rom image, four bytes per line
   localparam string     ROM_FILE  = "hdl/font_rom.hex";

   // every window above is size aligned and a power of two

endpackage

// File: hdl/compy_bus_pkg.sv
package compy_bus_pkg;

   // arbiter sequence: sample, issue, answer
   typedef enum logic [1:0] {
      ARB_IDLE,     // sample video or host request
      ARB_ACCESS,   // bank access or register write
      ARB_REPLY     // data back with ack or done
   } arb_state_e;

   // offsets inside the register window
   localparam logic [6:0] REG_PAGE        = 7'd0;   // video page, rw
   localparam logic [6:0] REG_FETCH_COUNT = 7'd1;   // served fetches, ro

   // offset from the video fetch unit
   typedef logic [13:0] fetch_addr_t;

   // page register counts 512 byte units
   localparam int PAGE_SHIFT = 9;

   // a fetch address is (page << PAGE_SHIFT) + offset,
   // cut down to the 16 bit bus

   // the fetch count wraps at 256, one step per ack

   // offsets other than the two above read as zero

endpackage

// File: hdl/host_req_if.sv
`timescale 1ns/1ps

interface host_req_if;
   import compy_map_pkg::*;

   logic      req;     // held until done
   logic      wr;
   bus_addr_t addr;
   bus_data_t wdata;
   logic      done;    // one cycle pulse
   bus_data_t rdata;
   logic      err;     // valid with done

   modport requester (
      output req,
      output wr,
      output addr,
      output wdata,
      input  done,
      input  rdata,
      input  err
   );

   modport server (
      input  req,
      input  wr,
      input  addr,
      input  wdata,
      output done,
      output rdata,
      output err
   );
endinterface

// File: hdl/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
   import compy_map_pkg::*;

   logic      en;       // one cycle per access
   logic      wr;
   target_e   target;   // bank select
   bus_addr_t index;    // offset inside the bank
   bus_data_t wdata;
   bus_data_t rdata;    // one cycle after a read en

   modport master (
      output en,
      output wr,
      output target,
      output index,
      output wdata,
      input  rdata
   );

   modport bank (
      input  en,
      input  wr,
      input  target,
      input  index,
      input  wdata,
      output rdata
   );

endinterface

// File: hdl/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port (
   input  logic                     CLK_200,
   input  logic                     reset_n,
   input  compy_map_pkg::bus_addr_t paddr,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  compy_map_pkg::bus_data_t pwdata,
   output compy_map_pkg::bus_data_t prdata,
   output logic                     pready,
   output logic                     pslverr,
   host_req_if.requester            host
);
   import compy_map_pkg::*;

   logic      req_q;     // one host request per transfer
   logic      wr_q;
   bus_addr_t addr_q;
   bus_data_t wdata_q;
   logic      setup;

   // setup phase of a new transfer, request not yet raised
   assign setup = psel && !penable && !req_q;

   always_ff @(posedge CLK_200) begin
      if (!reset_n) begin
         req_q   <= 1'b0;
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= host.done;               // ends the access phase
         pslverr <= host.done && host.err;
         if (host.done) begin
            req_q <= 1'b0;                   // low the cycle after done
         end else if (setup) begin
            req_q <= 1'b1;                   // high in first access cycle
         end
      end
   end

   // fields captured once so they stay stable while req is up
   always_ff @(posedge CLK_200) begin
      if (setup) begin
         addr_q  <= paddr;
         wr_q    <= pwrite;
         wdata_q <= pwdata;
      end
      if (host.done) begin
         prdata <= host.rdata;               // zero on error
      end
   end

   assign host.req   = req_q;
   assign host.wr    = wr_q;
   assign host.addr  = addr_q;
   assign host.wdata = wdata_q;

   // pready and pslverr come one cycle after done, so the master sees
   // the reply on the same edge as prdata

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                       CLK_200,
   input  logic                       reset_n,
   host_req_if.server                 host,
   mem_req_if.master                  mem,
   input  logic                       video_rd_req,
   input  compy_bus_pkg::fetch_addr_t video_addr,
   output compy_map_pkg::bus_data_t   video_rd_data,
   output logic                       video_rd_ack
);
   import compy_map_pkg::*;
   import compy_bus_pkg::*;

   arb_state_e state;
   bus_data_t  page_q;          // video page, 512 byte units
   bus_data_t  fetch_count_q;

   bus_addr_t  fetch_addr;
   bus_addr_t  sel_addr;
   target_e    sel_target;
   bus_addr_t  sel_index;
   logic       sel_err;

   target_e    cur_target;
   bus_addr_t  cur_index;
   logic       cur_wr;
   bus_data_t  cur_wdata;
   logic       cur_video;       // access belongs to the fetch unit
   logic       cur_err;
   bus_data_t  reg_rdata;
   bus_data_t  reply_data;

   function automatic logic in_window(bus_addr_t a, bus_addr_t base, int size);
      return (a & ~bus_addr_t'(size - 1)) == base;
   endfunction

   assign fetch_addr = (bus_addr_t'(page_q) << PAGE_SHIFT) + bus_addr_t'(video_addr);
   assign sel_addr   = video_rd_req ? fetch_addr : host.addr;   // video first

   always_comb begin
      sel_target = TGT_NONE;
      sel_index  = '0;
      if (in_window(sel_addr, RAM_BASE, RAM_SIZE)) begin
         sel_target = TGT_RAM;
         sel_index  = sel_addr - RAM_BASE;
      end else if (in_window(sel_addr, VRAM_BASE, VRAM_SIZE)) begin
         sel_target = TGT_VRAM;
         sel_index  = sel_addr - VRAM_BASE;
      end else if (in_window(sel_addr, ROM_BASE, ROM_SIZE)) begin
         sel_target = TGT_ROM;
         sel_index  = sel_addr - ROM_BASE;
      end else if (in_window(sel_addr, REG_BASE, REG_SIZE)) begin
         sel_target = TGT_REGS;
         sel_index  = sel_addr - REG_BASE;
      end
   end

   // only host accesses report errors
   always_comb begin
      sel_err = 1'b0;
      if (!video_rd_req) begin
         case (sel_target)
            TGT_NONE: sel_err = 1'b1;
            TGT_ROM:  sel_err = host.wr;
            TGT_REGS: sel_err = host.wr && (sel_index[6:0] == REG_FETCH_COUNT);
            default:  sel_err = 1'b0;
         endcase
      end
   end

   always_ff @(posedge CLK_200) begin
      if (!reset_n) begin
         state         <= ARB_IDLE;
         page_q        <= '0;
         fetch_count_q <= '0;
         cur_target    <= TGT_NONE;
         cur_wr        <= 1'b0;
         cur_video     <= 1'b0;
         cur_err       <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (video_rd_req || host.req) begin
                  state      <= ARB_ACCESS;
                  cur_target <= sel_target;
                  cur_wr     <= !video_rd_req && host.wr;
                  cur_video  <= video_rd_req;
                  cur_err    <= sel_err;
               end
            end
            ARB_ACCESS: begin
               state <= ARB_REPLY;
               if (cur_wr && !cur_err && cur_target == TGT_REGS &&
                   cur_index[6:0] == REG_PAGE) begin
                  page_q <= cur_wdata;
               end
            end
            ARB_REPLY: begin
               state <= ARB_IDLE;
               if (cur_video) begin
                  fetch_count_q <= fetch_count_q + 8'd1;   // wraps at 256
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK_200) begin
      if (state == ARB_IDLE) begin
         cur_index <= sel_index;
         cur_wdata <= host.wdata;
      end
   end

   // register reads answered here, banks stay idle
   always_comb begin
      if (cur_index[6:0] == REG_PAGE) begin
         reg_rdata = page_q;
      end else if (cur_index[6:0] == REG_FETCH_COUNT) begin
         reg_rdata = fetch_count_q;
      end else begin
         reg_rdata = '0;
      end
   end

   always_comb begin
      case (cur_target)
         TGT_RAM, TGT_VRAM, TGT_ROM: reply_data = mem.rdata;
         TGT_REGS:                   reply_data = reg_rdata;
         default:                    reply_data = '0;
      endcase
      if (cur_err) begin
         reply_data = '0;
      end
   end

   assign mem.en    = (state == ARB_ACCESS) && !cur_err &&
                      (cur_target inside {TGT_RAM, TGT_VRAM, TGT_ROM});
   assign mem.wr    = cur_wr;
   assign mem.target = cur_target;
   assign mem.index = cur_index;
   assign mem.wdata = cur_wdata;

   assign video_rd_ack  = (state == ARB_REPLY) && cur_video;
   assign video_rd_data = reply_data;
   assign host.done     = (state == ARB_REPLY) && !cur_video;
   assign host.rdata    = reply_data;
   assign host.err      = cur_err;   // sampled with done

endmodule

// File: hdl/mem_banks.sv
`timescale 1ns/1ps

module mem_banks (
   input  logic    CLK_200,
   mem_req_if.bank mem
);
   import compy_map_pkg::*;

   bus_data_t ram  [RAM_SIZE];
   bus_data_t vram [VRAM_SIZE];
   bus_data_t rom  [ROM_SIZE];

   logic [$clog2(RAM_SIZE)-1:0]  ram_idx;
   logic [$clog2(VRAM_SIZE)-1:0] vram_idx;
   logic [$clog2(ROM_SIZE)-1:0]  rom_idx;
   bus_data_t                    rdata_q;

   // font bytes
   initial begin
      $readmemh(ROM_FILE, rom);
   end

   assign ram_idx  = mem.index[$clog2(RAM_SIZE)-1:0];
   assign vram_idx = mem.index[$clog2(VRAM_SIZE)-1:0];
   assign rom_idx  = mem.index[$clog2(ROM_SIZE)-1:0];

   always_ff @(posedge CLK_200) begin
      if (mem.en) begin
         case (mem.target)
            TGT_RAM: begin
               if (mem.wr) begin
                  ram[ram_idx] <= mem.wdata;
               end else begin
                  rdata_q <= ram[ram_idx];
               end
            end
            TGT_VRAM: begin
               if (mem.wr) begin
                  vram[vram_idx] <= mem.wdata;
               end else begin
                  rdata_q <= vram[vram_idx];
               end
            end
            TGT_ROM: begin
               if (!mem.wr) begin
                  rdata_q <= rom[rom_idx];   // read only
               end
            end
            default: begin
               rdata_q <= '0;   // regs and unmapped never reach here
            end
         endcase
      end
   end

   assign mem.rdata = rdata_q;   // valid the cycle after en

endmodule

// File: hdl/compy_bus.sv
`timescale 1ns/1ps

module compy_bus (
   input  logic                       CLK_200,
   input  logic                       reset_n,
   input  compy_map_pkg::bus_addr_t   paddr,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  compy_map_pkg::bus_data_t   pwdata,
   output compy_map_pkg::bus_data_t   prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic                       video_rd_req,
   input  compy_bus_pkg::fetch_addr_t video_addr,
   output compy_map_pkg::bus_data_t   video_rd_data,
   output logic                       video_rd_ack
);

   host_req_if host_bus ();   // apb port to arbiter
   mem_req_if  mem_bus ();    // arbiter to banks

   apb_host_port u_apb_port (
      .CLK_200 (CLK_200),
      .reset_n (reset_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .host    (host_bus.requester)
   );

   bus_arbiter u_arbiter (
      .CLK_200       (CLK_200),
      .reset_n       (reset_n),
      .host          (host_bus.server),
      .mem           (mem_bus.master),
      .video_rd_req  (video_rd_req),
      .video_addr    (video_addr),
      .video_rd_data (video_rd_data),
      .video_rd_ack  (video_rd_ack)
   );

   mem_banks u_banks (
      .CLK_200 (CLK_200),
      .mem     (mem_bus.bank)
   );

endmodule

// File: bench/compy_bus_tb.sv
`timescale 1ns/1ps

module compy_bus_tb;
   import compy_map_pkg::*;
   import compy_bus_pkg::*;

   localparam int TIMEOUT_CYCLES = 4000;   // about twice the test length
   localparam int BURST_LEN      = 260;    // enough fetches to wrap the count

   logic        CLK_200 = 1'b0;
   logic        reset_n;
   bus_addr_t   paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   bus_data_t   pwdata;
   bus_data_t   prdata;
   logic        pready;
   logic        pslverr;
   logic        video_rd_req;
   fetch_addr_t video_addr;
   bus_data_t   video_rd_data;
   logic        video_rd_ack;

   // reference memory model
   bus_data_t   ram_m  [4096];
   bus_data_t   vram_m [2048];
   bus_data_t   rom_m  [64];
   bus_data_t   page_m;
   int          fetch_total;

   int          errors = 0;
   int          checks = 0;
   int          cycle_count = 0;
   integer      seed;

   compy_bus dut0 (
      .CLK_200       (CLK_200),
      .reset_n       (reset_n),
      .paddr         (paddr),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .video_rd_req  (video_rd_req),
      .video_addr    (video_addr),
      .video_rd_data (video_rd_data),
      .video_rd_ack  (video_rd_ack)
   );

   always #5 CLK_200 = ~CLK_200;

   always @(posedge CLK_200) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function automatic bus_data_t model_byte(input bus_addr_t a);
      if (a <= 16'h0FFF) return ram_m[a[11:0]];
      if (a >= 16'hA000 && a <= 16'hA7FF) return vram_m[a[10:0]];
      if (a >= 16'hE000 && a <= 16'hE03F) return rom_m[a[5:0]];
      if (a == 16'h9000) return page_m;
      if (a == 16'h9001) return bus_data_t'(fetch_total);   // wraps at 256
      return 8'h00;                                         // spare regs, unmapped
   endfunction

   function automatic logic host_error(input bus_addr_t a, input logic wr);
      logic mapped;
      mapped = (a <= 16'h0FFF) || (a >= 16'hA000 && a <= 16'hA7FF) ||
               (a >= 16'h9000 && a <= 16'h907F) || (a >= 16'hE000 && a <= 16'hE03F);
      if (!mapped) return 1'b1;
      if (wr && a >= 16'hE000) return 1'b1;   // rom write
      return wr && (a == 16'h9001);           // fetch count write
   endfunction

   function automatic void model_write(input bus_addr_t a, input bus_data_t d);
      if (a <= 16'h0FFF) ram_m[a[11:0]] = d;
      else if (a >= 16'hA000 && a <= 16'hA7FF) vram_m[a[10:0]] = d;
      else if (a == 16'h9000) page_m = d;
   endfunction

   task automatic apb_transfer(input bus_addr_t a, input logic wr, input bus_data_t d,
                               output bus_data_t rd, output logic err);
      @(posedge CLK_200);
      #1;
      paddr   = a;      // setup phase
      pwrite  = wr;
      pwdata  = d;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge CLK_200);
      #1;
      penable = 1'b1;
      @(posedge CLK_200);
      #1;
      while (!pready) begin
         @(posedge CLK_200);
         #1;
      end
      rd  = prdata;
      err = pslverr;
      @(posedge CLK_200);   // transfer ends on this edge
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input bus_addr_t a, input bus_data_t d);
      bus_data_t rd;
      logic      err;
      logic      exp_err;
      exp_err = host_error(a, 1'b1);
      apb_transfer(a, 1'b1, d, rd, err);
      checks++;
      if (err !== exp_err) begin
         errors++;
         $display("error: pslverr on write to %h got %h expected %h", a, err, exp_err);
      end
      if (!exp_err) begin
         model_write(a, d);
      end
   endtask

   task automatic apb_read(input bus_addr_t a);
      bus_data_t rd;
      bus_data_t exp;
      logic      err;
      logic      exp_err;
      exp_err = host_error(a, 1'b0);
      apb_transfer(a, 1'b0, 8'h00, rd, err);
      exp = exp_err ? 8'h00 : model_byte(a);
      checks++;
      if (err !== exp_err) begin
         errors++;
         $display("error: pslverr on read of %h got %h expected %h", a, err, exp_err);
      end
      if (rd !== exp) begin
         errors++;
         $display("error: prdata at %h got %h expected %h", a, rd, exp);
      end
   endtask

   task automatic video_read(input fetch_addr_t off, input logic check_latency);
      bus_addr_t a;
      bus_data_t exp;
      int        lat;
      a = bus_addr_t'(32'(page_m) * 512 + 32'(off));   // cut to the 16 bit bus
      @(posedge CLK_200);
      #1;
      video_addr   = off;
      video_rd_req = 1'b1;
      @(posedge CLK_200);
      #1;
      lat = 1;
      while (!video_rd_ack) begin
         @(posedge CLK_200);
         #1;
         lat++;
      end
      exp = model_byte(a);   // count register shows fetches before this one
      video_rd_req = 1'b0;
      checks++;
      if (video_rd_data !== exp) begin
         errors++;
         $display("error: video_rd_data at %h got %h expected %h", a, video_rd_data, exp);
      end
      if (check_latency && lat != 2) begin
         errors++;
         $display("video ack came %0d cycles after the request instead of 2", lat);
      end
      fetch_total++;
   endtask

   task automatic test_reset_values();
      apb_read(16'h9000);
      apb_read(16'h9001);
   endtask

   task automatic test_ram_vram_rom();
      bus_addr_t addrs[$];
      bus_addr_t a;
      for (int i = 0; i < 16; i++) begin
         a = bus_addr_t'($random(seed)) & 16'h0FFF;
         addrs.push_back(a);
         apb_write(a, bus_data_t'($random(seed)));
      end
      for (int i = 0; i < 16; i++) begin
         a = 16'hA000 | (bus_addr_t'($random(seed)) & 16'h07FF);
         addrs.push_back(a);
         apb_write(a, bus_data_t'($random(seed)));
      end
      foreach (addrs[i]) begin
         apb_read(addrs[i]);
      end
      for (int i = 0; i < 64; i++) begin
         apb_read(bus_addr_t'(16'hE000 + i));
      end
   endtask

   task automatic test_bus_errors();
      apb_write(16'h0000, 8'hC3);   // would alias with 0x1000 on a bad decode
      apb_write(16'hE005, 8'h5A);
      apb_write(16'h9001, 8'h33);
      apb_read(16'h9090);
      apb_write(16'h9090, 8'h11);
      apb_read(16'h1000);
      apb_write(16'h1000, 8'h22);
      apb_write(16'h9010, 8'h77);   // spare register, no error
      apb_read(16'h9010);
      apb_read(16'h0000);
      apb_read(16'hE005);
      apb_read(16'h9001);
      apb_read(16'h9000);
   endtask

   task automatic test_video_fetch();
      for (int i = 0; i < 8; i++) begin
         apb_write(bus_addr_t'(16'hA200 + i), bus_data_t'($random(seed)));
      end
      for (int i = 0; i < 4; i++) begin
         apb_write(bus_addr_t'(16'h0010 + i), bus_data_t'($random(seed)));
      end
      apb_write(16'h9000, 8'h51);   // page starts at 0xA200
      apb_read(16'h9000);
      for (int i = 0; i < 8; i++) begin
         video_read(fetch_addr_t'(i), 1'b1);
      end
      apb_write(16'h9000, 8'h70);   // font rom
      video_read(14'h0000, 1'b1);
      video_read(14'h0009, 1'b1);
      video_read(14'h0021, 1'b1);
      video_read(14'h003F, 1'b1);
      apb_write(16'h9000, 8'hFF);   // wraps past 0xFFFF into ram
      for (int i = 0; i < 4; i++) begin
         video_read(fetch_addr_t'(16'h0210 + i), 1'b1);
      end
      apb_write(16'h9000, 8'h48);   // register window
      video_read(14'h0000, 1'b1);
      video_read(14'h0001, 1'b1);
      apb_write(16'h9000, 8'h00);
      video_read(14'h1000, 1'b1);   // unmapped
   endtask

   task automatic test_contention();
      bus_data_t d;
      d = bus_data_t'($random(seed));
      apb_write(16'h9000, 8'h70);
      fork
         apb_write(16'h0234, d);   // served once the burst stops
         begin
            for (int i = 0; i < BURST_LEN; i++) begin
               video_read(fetch_addr_t'(i % 64), 1'b0);
            end
         end
      join
      apb_read(16'h0234);
      apb_read(16'h9001);
   endtask

   initial begin
      seed         = 32'h396b;
      reset_n      = 1'b0;
      paddr        = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      pwdata       = '0;
      video_rd_req = 1'b0;
      video_addr   = '0;
      page_m       = 8'h00;
      fetch_total  = 0;
      $readmemh(ROM_FILE, rom_m);
      repeat (3) @(posedge CLK_200);
      #1;
      reset_n = 1'b1;
      test_reset_values();
      test_ram_vram_rom();
      test_bus_errors();
      test_video_fetch();
      test_contention();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: hdl/font_rom.hex
// font rom image, four bytes per line, lowest address first, glyphs A to H
18 3C 66 66
7E 66 66 00
7C 66 66 7C
66 66 7C 00
3C 66 60 60
60 66 3C 00
78 6C 66 66
66 6C 78 00
7E 60 60 78
60 60 7E 00
7E 60 60 78
60 60 60 00
3C 66 60 6E
66 66 3C 00
66 66 66 7E
66 66 66 00

// File: compy_bus.f
hdl/compy_map_pkg.sv
hdl/compy_bus_pkg.sv
hdl/host_req_if.sv
hdl/mem_req_if.sv
hdl/apb_host_port.sv
hdl/bus_arbiter.sv
hdl/mem_banks.sv
hdl/compy_bus.sv
bench/compy_bus_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := compy_bus_tb
RTL_TOP    := compy_bus
FILELIST   := compy_bus.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
